//--- hw/apb_csr_regs.sv
`timescale 1ns/1ns
module apb_csr_regs import mmu_pkg::*; (
    input  logic                   apb,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [PADDR_WIDTH-1:0] paddr,
    input  logic [DATA_WIDTH-1:0]  pwdata,
    output logic [DATA_WIDTH-1:0]  prdata,
    output logic                   pready,
    output logic                   pslverr,
    mmu_ctrl_if.csr                ctrl,
    output logic                   mem_en,
    output logic                   mem_we,
    output logic [AWIDTH-1:0]      mem_addr,
    output logic [DATA_WIDTH-1:0]  mem_wdata,
    input  logic [DATA_WIDTH-1:0]  mem_rdata
);

    logic                  access;
    logic                  win_sel;
    logic                  win_rd;
    logic                  rd_wait;
    logic                  csr_wr;
    logic                  start_req;
    logic [DATA_WIDTH-1:0] csr_rdata;

    assign access    = psel && penable;
    assign win_sel   = paddr[PADDR_WIDTH-1];
    assign win_rd    = access && win_sel && !pwrite && !ctrl.busy;
    assign csr_wr    = access && !win_sel && pwrite;
    assign start_req = csr_wr && (paddr == ADDR_START) && pwdata[0];

    // One wait state on window reads, none elsewhere
    assign pready  = !(win_rd && !rd_wait);
    assign pslverr = access && win_sel && ctrl.busy;

    // Memory read is issued in the first access cycle only
    assign mem_en    = access && win_sel && !ctrl.busy && (pwrite || !rd_wait);
    assign mem_we    = pwrite;
    assign mem_addr  = paddr[AWIDTH-1:0];
    assign mem_wdata = pwdata;

    always_ff @(posedge apb or negedge arst_n) begin
        if (!arst_n) begin
            rd_wait          <= 1'b0;
            ctrl.start_pulse <= 1'b0;
            ctrl.start_busy  <= 1'b0;
            ctrl.is_int4     <= 1'b0;
            ctrl.addr_a      <= '0;
            ctrl.addr_b      <= '0;
            ctrl.addr_c      <= '0;
            ctrl.stride_a    <= '0;
            ctrl.stride_b    <= '0;
            ctrl.stride_c    <= '0;
        end else begin
            rd_wait          <= win_rd && !rd_wait;
            ctrl.start_pulse <= start_req && !ctrl.busy;
            ctrl.start_busy  <= start_req && ctrl.busy;
            if (csr_wr) begin
                case (paddr)
                    ADDR_MAT_A:    ctrl.addr_a   <= pwdata[AWIDTH-1:0];
                    ADDR_MAT_B:    ctrl.addr_b   <= pwdata[AWIDTH-1:0];
                    ADDR_MAT_C:    ctrl.addr_c   <= pwdata[AWIDTH-1:0];
                    ADDR_STRIDE_A: ctrl.stride_a <= pwdata[STRIDE_WIDTH-1:0];
                    ADDR_STRIDE_B: ctrl.stride_b <= pwdata[STRIDE_WIDTH-1:0];
                    ADDR_STRIDE_C: ctrl.stride_c <= pwdata[STRIDE_WIDTH-1:0];
                    ADDR_IS_INT4:  ctrl.is_int4  <= pwdata[0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (paddr)
            // Start reads back as the busy bit
            ADDR_START:    csr_rdata = DATA_WIDTH'(ctrl.busy);
            ADDR_MAT_A:    csr_rdata = DATA_WIDTH'(ctrl.addr_a);
            ADDR_MAT_B:    csr_rdata = DATA_WIDTH'(ctrl.addr_b);
            ADDR_MAT_C:    csr_rdata = DATA_WIDTH'(ctrl.addr_c);
            ADDR_STRIDE_A: csr_rdata = DATA_WIDTH'(ctrl.stride_a);
            ADDR_STRIDE_B: csr_rdata = DATA_WIDTH'(ctrl.stride_b);
            ADDR_STRIDE_C: csr_rdata = DATA_WIDTH'(ctrl.stride_c);
            ADDR_STATUS:   csr_rdata = DATA_WIDTH'({ctrl.flags, ctrl.done});
            ADDR_IS_INT4:  csr_rdata = DATA_WIDTH'(ctrl.is_int4);
            default:       csr_rdata = '0;
        endcase
    end

    // Window reads return zero while the engine runs
    assign prdata = win_sel ? (ctrl.busy ? '0 : mem_rdata) : csr_rdata;

endmodule

//--- hw/mat_scratchpad.sv
`timescale 1ns/1ns
module mat_scratchpad import mmu_pkg::*; (
    input  logic                  apb,
    input  logic [AWIDTH-1:0]     ra_addr,
    input  logic [AWIDTH-1:0]     rb_addr,
    output logic [DATA_WIDTH-1:0] ra_data,
    output logic [DATA_WIDTH-1:0] rb_data,
    input  logic                  en,
    input  logic                  we,
    input  logic [AWIDTH-1:0]     addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata
);

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    // Engine operand ports, read every cycle
    always_ff @(posedge apb) begin
        ra_data <= mem[ra_addr];
        rb_data <= mem[rb_addr];
    end

    // Shared port, old data on a write
    always_ff @(posedge apb) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/matmul_engine.sv
`timescale 1ns/1ns
module matmul_engine import mmu_pkg::*; (
    input  logic                  apb,
    input  logic                  arst_n,
    mmu_ctrl_if.engine            ctrl,
    output logic [AWIDTH-1:0]     ra_addr,
    output logic [AWIDTH-1:0]     rb_addr,
    input  logic [DATA_WIDTH-1:0] ra_data,
    input  logic [DATA_WIDTH-1:0] rb_data,
    output logic                  wr_en,
    output logic [AWIDTH-1:0]     wr_addr,
    output logic [DATA_WIDTH-1:0] wr_data,
    output mat_flags_t            eng_flags
);

    // Unwrapped address, base + row * stride + col
    function automatic logic [EXT_AWIDTH-1:0] addr_calc(
        input logic [AWIDTH-1:0]       base,
        input logic [IDX_WIDTH-1:0]    row,
        input logic [STRIDE_WIDTH-1:0] stride,
        input logic [IDX_WIDTH-1:0]    col
    );
        return EXT_AWIDTH'(base) + EXT_AWIDTH'(row) * EXT_AWIDTH'(stride)
            + EXT_AWIDTH'(col);
    endfunction

    logic                         busy_q;
    logic                         issuing;
    logic [IDX_WIDTH-1:0]         i_q, j_q, k_q;
    logic                         v1, first1, last1;
    logic [IDX_WIDTH-1:0]         i1, j1;
    logic                         v2, first2, last2;
    logic [IDX_WIDTH-1:0]         i2, j2;
    logic [EXT_AWIDTH-1:0]        a_full, b_full, c_full;
    logic                         issue_last;
    logic                         issue_wrap;
    logic                         c_wrap;
    logic                         write_now;
    elem_u                        elem_a, elem_b;
    logic signed [15:0]           prod8;
    logic signed [8:0]            prod4;
    logic signed [DATA_WIDTH-1:0] prod, acc, sum;
    logic                         sum_ovf;
    logic                         ovf_q, wrap_q, zero_q;

    always_comb begin
        a_full     = addr_calc(ctrl.addr_a, i_q, ctrl.stride_a, k_q);
        b_full     = addr_calc(ctrl.addr_b, k_q, ctrl.stride_b, j_q);
        c_full     = addr_calc(ctrl.addr_c, i2, ctrl.stride_c, j2);
        issue_last = (i_q == IDX_LAST) && (j_q == IDX_LAST) && (k_q == IDX_LAST);
        issue_wrap = issuing && ((a_full[EXT_AWIDTH-1:AWIDTH] != '0)
            || (b_full[EXT_AWIDTH-1:AWIDTH] != '0));
        c_wrap     = c_full[EXT_AWIDTH-1:AWIDTH] != '0;

        // Stage 1 operands
        elem_a = ra_data[$bits(elem_u)-1:0];
        elem_b = rb_data[$bits(elem_u)-1:0];
        prod8  = elem_a.s8 * elem_b.s8;
        prod4  = elem_a.lanes.hi * elem_b.lanes.hi + elem_a.lanes.lo * elem_b.lanes.lo;

        // Stage 2 accumulate
        sum       = first2 ? prod : acc + prod;
        sum_ovf   = !((&sum[DATA_WIDTH-1:15]) || !(|sum[DATA_WIDTH-1:15]));
        write_now = v2 && last2;
    end

    assign ra_addr   = a_full[AWIDTH-1:0];
    assign rb_addr   = b_full[AWIDTH-1:0];
    assign ctrl.busy = busy_q;

    always_ff @(posedge apb or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            issuing <= 1'b0;
            i_q     <= '0;
            j_q     <= '0;
            k_q     <= '0;
            v1      <= 1'b0;
            v2      <= 1'b0;
            wr_en   <= 1'b0;
            ovf_q   <= 1'b0;
            wrap_q  <= 1'b0;
            zero_q  <= 1'b0;
        end else begin
            v1    <= issuing;
            v2    <= v1;
            wr_en <= write_now;
            if (ctrl.start_pulse) begin
                busy_q  <= 1'b1;
                issuing <= 1'b1;
                i_q     <= '0;
                j_q     <= '0;
                k_q     <= '0;
                ovf_q   <= 1'b0;
                wrap_q  <= 1'b0;
                zero_q  <= 1'b1;
            end else begin
                // Row-major walk, k innermost
                if (issuing) begin
                    k_q <= k_q + 1'b1;
                    if (k_q == IDX_LAST) begin
                        j_q <= j_q + 1'b1;
                        if (j_q == IDX_LAST) begin
                            i_q <= i_q + 1'b1;
                        end
                    end
                    if (issue_last) begin
                        issuing <= 1'b0;
                    end
                end
                if (issue_wrap || (write_now && c_wrap)) begin
                    wrap_q <= 1'b1;
                end
                if (write_now && sum_ovf) begin
                    ovf_q <= 1'b1;
                end
                if (write_now && (sum != '0)) begin
                    zero_q <= 1'b0;
                end
                // Last write leaves the pipe empty
                if (wr_en && !issuing && !v1 && !v2) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge apb) begin
        first1  <= (k_q == '0);
        last1   <= (k_q == IDX_LAST);
        i1      <= i_q;
        j1      <= j_q;
        first2  <= first1;
        last2   <= last1;
        i2      <= i1;
        j2      <= j1;
        prod    <= ctrl.is_int4 ? prod4 : prod8;
        if (v2) begin
            acc <= sum;
        end
        wr_addr <= c_full[AWIDTH-1:0];
        wr_data <= sum;
    end

    always_comb begin
        eng_flags            = '0;
        eng_flags[FLAG_OVF]  = ovf_q;
        eng_flags[FLAG_WRAP] = wrap_q;
        eng_flags[FLAG_ZERO] = zero_q;
    end

endmodule

//--- hw/matmul_status.sv
`timescale 1ns/1ns
module matmul_status import mmu_pkg::*; (
    input  logic       apb,
    input  logic       arst_n,
    mmu_ctrl_if.status ctrl,
    input  mat_flags_t eng_flags
);

    logic       busy_q;
    logic       done_q;
    logic       run_end;
    logic       overlap;
    mat_flags_t flags_q, flags_n;

    assign run_end = busy_q && !ctrl.busy;

    always_comb begin
        // Rows of A or B would overlap
        overlap = (ctrl.stride_a < MAT_N) || (ctrl.stride_b < MAT_N);
        flags_n = flags_q;
        if (ctrl.start_pulse) begin
            flags_n               = '0;
            flags_n[FLAG_OVERLAP] = overlap;
        end else begin
            if (ctrl.start_busy) begin
                flags_n[FLAG_BUSY_START] = 1'b1;
            end
            if (run_end) begin
                flags_n = flags_n | (eng_flags & ENG_FLAG_MASK);
            end
        end
    end

    always_ff @(posedge apb or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            flags_q <= '0;
        end else begin
            busy_q  <= ctrl.busy;
            flags_q <= flags_n;
            if (ctrl.start_pulse) begin
                done_q <= 1'b0;
            end else if (run_end) begin
                done_q <= 1'b1;
            end
        end
    end

    assign ctrl.done  = done_q;
    assign ctrl.flags = flags_q;

endmodule

//--- hw/matmul_top.sv
`timescale 1ns/1ns
module matmul_top import mmu_pkg::*; (
    input  logic                   apb,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [PADDR_WIDTH-1:0] paddr,
    input  logic [DATA_WIDTH-1:0]  pwdata,
    output logic [DATA_WIDTH-1:0]  prdata,
    output logic                   pready,
    output logic                   pslverr
);

    mmu_ctrl_if ctrl_if_inst ();

    logic                  csr_mem_en, csr_mem_we;
    logic [AWIDTH-1:0]     csr_mem_addr;
    logic [DATA_WIDTH-1:0] csr_mem_wdata;
    logic                  sp_en, sp_we;
    logic [AWIDTH-1:0]     sp_addr;
    logic [DATA_WIDTH-1:0] sp_wdata, sp_rdata;
    logic [AWIDTH-1:0]     ra_addr, rb_addr;
    logic [DATA_WIDTH-1:0] ra_data, rb_data;
    logic                  eng_wr_en;
    logic [AWIDTH-1:0]     eng_wr_addr;
    logic [DATA_WIDTH-1:0] eng_wr_data;
    mat_flags_t            eng_flags;

    // Engine owns the shared port for the whole run
    assign sp_en    = ctrl_if_inst.busy ? eng_wr_en : csr_mem_en;
    assign sp_we    = ctrl_if_inst.busy ? eng_wr_en : csr_mem_we;
    assign sp_addr  = ctrl_if_inst.busy ? eng_wr_addr : csr_mem_addr;
    assign sp_wdata = ctrl_if_inst.busy ? eng_wr_data : csr_mem_wdata;

    apb_csr_regs csr_inst (
        .apb(apb), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .ctrl(ctrl_if_inst.csr),
        .mem_en(csr_mem_en), .mem_we(csr_mem_we), .mem_addr(csr_mem_addr),
        .mem_wdata(csr_mem_wdata), .mem_rdata(sp_rdata)
    );

    mat_scratchpad scratchpad_inst (
        .apb(apb),
        .ra_addr(ra_addr), .rb_addr(rb_addr), .ra_data(ra_data), .rb_data(rb_data),
        .en(sp_en), .we(sp_we), .addr(sp_addr), .wdata(sp_wdata), .rdata(sp_rdata)
    );

    matmul_engine engine_inst (
        .apb(apb), .arst_n(arst_n), .ctrl(ctrl_if_inst.engine),
        .ra_addr(ra_addr), .rb_addr(rb_addr), .ra_data(ra_data), .rb_data(rb_data),
        .wr_en(eng_wr_en), .wr_addr(eng_wr_addr), .wr_data(eng_wr_data),
        .eng_flags(eng_flags)
    );

    matmul_status status_inst (
        .apb(apb), .arst_n(arst_n), .ctrl(ctrl_if_inst.status), .eng_flags(eng_flags)
    );

endmodule

//--- hw/mmu_ctrl_if.sv
`timescale 1ns/1ns
interface mmu_ctrl_if import mmu_pkg::*; ();

    logic                    start_pulse;
    // Start written while the engine was running
    logic                    start_busy;
    logic                    is_int4;
    logic [AWIDTH-1:0]       addr_a;
    logic [AWIDTH-1:0]       addr_b;
    logic [AWIDTH-1:0]       addr_c;
    logic [STRIDE_WIDTH-1:0] stride_a;
    logic [STRIDE_WIDTH-1:0] stride_b;
    logic [STRIDE_WIDTH-1:0] stride_c;
    logic                    busy;
    logic                    done;
    mat_flags_t              flags;

    modport csr (
        output start_pulse, start_busy, is_int4, addr_a, addr_b, addr_c,
               stride_a, stride_b, stride_c,
        input  busy, done, flags
    );

    modport engine (
        input  start_pulse, is_int4, addr_a, addr_b, addr_c, stride_a, stride_b, stride_c,
        output busy
    );

    modport status (
        input  start_pulse, start_busy, is_int4, addr_a, addr_b, addr_c,
               stride_a, stride_b, stride_c, busy,
        output done, flags
    );

endinterface

//--- hw/mmu_pkg.sv
package mmu_pkg;

    // Matrix and datapath sizes
    localparam int MAT_N        = 4;
    localparam int IDX_WIDTH    = $clog2(MAT_N);
    localparam int AWIDTH       = 8;
    localparam int EXT_AWIDTH   = AWIDTH + 2;
    localparam int MEM_DEPTH    = 1 << AWIDTH;
    localparam int STRIDE_WIDTH = 8;
    localparam int DATA_WIDTH   = 32;
    localparam int PADDR_WIDTH  = 9;
    localparam int FLAG_WIDTH   = 5;

    localparam logic [IDX_WIDTH-1:0] IDX_LAST = IDX_WIDTH'(MAT_N - 1);

    // CSR word addresses
    // Window accesses have the top paddr bit set
    localparam logic [PADDR_WIDTH-1:0] ADDR_START    = PADDR_WIDTH'(0);
    localparam logic [PADDR_WIDTH-1:0] ADDR_MAT_A    = PADDR_WIDTH'(1);
    localparam logic [PADDR_WIDTH-1:0] ADDR_MAT_B    = PADDR_WIDTH'(2);
    localparam logic [PADDR_WIDTH-1:0] ADDR_MAT_C    = PADDR_WIDTH'(3);
    localparam logic [PADDR_WIDTH-1:0] ADDR_STRIDE_A = PADDR_WIDTH'(4);
    localparam logic [PADDR_WIDTH-1:0] ADDR_STRIDE_B = PADDR_WIDTH'(5);
    localparam logic [PADDR_WIDTH-1:0] ADDR_STRIDE_C = PADDR_WIDTH'(6);
    localparam logic [PADDR_WIDTH-1:0] ADDR_STATUS   = PADDR_WIDTH'(7);
    localparam logic [PADDR_WIDTH-1:0] ADDR_IS_INT4  = PADDR_WIDTH'(8);

    // Bit positions in the flags field
    localparam int FLAG_OVF        = 0;
    localparam int FLAG_WRAP       = 1;
    localparam int FLAG_BUSY_START = 2;
    localparam int FLAG_ZERO       = 3;
    localparam int FLAG_OVERLAP    = 4;

    typedef logic [FLAG_WIDTH-1:0] mat_flags_t;

    // Flags that the engine reports at the end of a run
    localparam mat_flags_t ENG_FLAG_MASK =
        FLAG_WIDTH'((1 << FLAG_OVF) | (1 << FLAG_WRAP) | (1 << FLAG_ZERO));

    typedef struct packed {
        logic signed [3:0] hi;
        logic signed [3:0] lo;
    } int4_pair_t;

    // Low byte of a scratchpad word, int8 or two int4 lanes
    typedef union packed {
        logic signed [7:0] s8;
        int4_pair_t        lanes;
    } elem_u;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass message in the log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module matmul_tb \
    -o matmul_sim > build.log 2>&1 \
    && ./obj_dir/matmul_sim > sim.log 2>&1 \
    && grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb/matmul_chk.sv
`timescale 1ns/1ns
module matmul_chk (
    input logic apb,
    input logic arst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr
);

    // Access phase must follow a setup cycle
    penable_after_setup: assert property (
        @(posedge apb) disable iff (!arst_n)
        $rose(penable) |-> $past(psel && !penable)
    ) else $error("penable rose without a setup cycle");

    // At most one wait state
    single_wait_state: assert property (
        @(posedge apb) disable iff (!arst_n)
        (psel && penable && !pready) |=> pready
    ) else $error("pready held low for more than one cycle");

    slverr_with_ready: assert property (
        @(posedge apb) disable iff (!arst_n)
        pslverr |-> pready
    ) else $error("pslverr high while pready low");

endmodule

bind matmul_top matmul_chk chk_inst (
    .apb(apb),
    .arst_n(arst_n),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr)
);

//--- tb/matmul_input.txt
# op addr(hex) data(hex) aux(hex): W write, R read with expected data and pslverr in aux,
# F fill aux words from addr with data, P poll status until done
R 001 0 0
R 004 0 0
R 007 0 0
R 008 0 0
W 001 1234 0
W 004 abc 0
W 008 3 0
R 001 34 0
R 004 bc 0
R 008 1 0
R 00f 0 0
R 000 0 0
F 100 0 100
F 180 80 10
W 100 02 0
W 101 ff 0
W 105 03 0
W 10a 7f 0
W 10f 81 0
# int8 run, A = B at 0x00 stride 4, C at 0x40 stride 4
W 001 0 0
W 002 0 0
W 003 40 0
W 004 4 0
W 005 4 0
W 006 4 0
W 008 0 0
W 000 1 0
P 0 0 0
R 007 1 0
R 140 4 0
R 141 fffffffb 0
R 144 0 0
R 145 9 0
R 14a 3f01 0
R 14f 3f01 0
# int4 lanes, C at 0x60 stride 8
W 008 1 0
W 003 60 0
W 006 8 0
W 000 1 0
P 0 0 0
R 007 1 0
R 160 4 0
R 161 fffffffb 0
R 169 9 0
R 172 32 0
R 17b 41 0
# Overflow and wrap, all 0x80 at 0x80, C at 0xf8
W 008 0 0
W 001 80 0
W 002 80 0
W 003 f8 0
W 006 4 0
W 000 1 0
P 0 0 0
R 007 7 0
R 1f8 10000 0
R 100 10000 0
# Zero and overlap, window and start during busy
W 001 c0 0
W 002 c0 0
W 003 d0 0
W 004 1 0
W 005 1 0
W 000 1 0
R 180 0 1
W 1c0 55 0
W 000 1 0
P 0 0 0
R 007 39 0
R 1c0 0 0
R 1d0 0 0
# New start clears done and flags
W 004 4 0
W 005 4 0
W 000 1 0
R 007 0 0
P 0 0 0
R 007 11 0

//--- tb/matmul_monitor.sv
`timescale 1ns/1ns
module matmul_monitor import mmu_pkg::*; (
    input  logic                   apb,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [PADDR_WIDTH-1:0] paddr,
    input  logic [DATA_WIDTH-1:0]  prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    // Expected response for the read in progress
    input  logic                   exp_en,
    input  logic [DATA_WIDTH-1:0]  exp_data,
    input  logic                   exp_err,
    output int                     errors
);

    logic in_access;
    logic one_wait;
    int   wait_cnt;
    int   exp_waits;

    assign in_access = psel && penable;
    // Only a window read that is not rejected gets a wait state
    assign one_wait  = !pwrite && paddr[PADDR_WIDTH-1] && !(exp_en && exp_err);

    initial begin
        errors    = 0;
        wait_cnt  = 0;
        exp_waits = 0;
    end

    always @(posedge apb) begin
        if (arst_n && in_access) begin
            if (!pready) begin
                wait_cnt = wait_cnt + 1;
            end else begin
                exp_waits = one_wait ? 1 : 0;
                if (wait_cnt != exp_waits) begin
                    errors = errors + 1;
                    $display("MISMATCH pready waits exp 0x%0h got 0x%0h",
                        exp_waits, wait_cnt);
                end
                wait_cnt = 0;
                if (!pwrite && exp_en) begin
                    if (prdata !== exp_data) begin
                        errors = errors + 1;
                        $display("MISMATCH prdata exp 0x%08h got 0x%08h", exp_data, prdata);
                    end
                    if (pslverr !== exp_err) begin
                        errors = errors + 1;
                        $display("MISMATCH pslverr exp 0x%0h got 0x%0h", exp_err, pslverr);
                    end
                end
            end
        end
    end

endmodule

//--- tb/matmul_tb.sv
`timescale 1ns/1ns
module matmul_tb import mmu_pkg::*; ();

    logic                   apb;
    logic                   arst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [PADDR_WIDTH-1:0] paddr;
    logic [DATA_WIDTH-1:0]  pwdata;
    logic [DATA_WIDTH-1:0]  prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   exp_en;
    logic [DATA_WIDTH-1:0]  exp_data;
    logic                   exp_err;
    int                     mon_errors;
    int                     drv_errors;
    int                     cycle_cnt;

    matmul_top matmul_top_inst (
        .apb(apb), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    matmul_monitor monitor_inst (
        .apb(apb), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .exp_en(exp_en), .exp_data(exp_data), .exp_err(exp_err),
        .errors(mon_errors)
    );

    always #4 apb = ~apb;

    // Free-running cycle count for the poll timeout
    always @(posedge apb) begin
        cycle_cnt = cycle_cnt + 1;
    end

    task automatic apb_xfer(
        input  logic                   wr,
        input  logic [PADDR_WIDTH-1:0] addr,
        input  logic [DATA_WIDTH-1:0]  data,
        output logic [DATA_WIDTH-1:0]  rd,
        output logic                   err
    );
        int waits;
        @(posedge apb);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge apb);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(posedge apb);
        while (!pready && waits < 16) begin
            waits = waits + 1;
            @(posedge apb);
        end
        if (!pready) begin
            drv_errors = drv_errors + 1;
            $display("ERROR: slave never raised pready at address 0x%03h", addr);
        end
        rd  = prdata;
        err = pslverr;
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        exp_en  = 1'b0;
    endtask

    // Poll the status word until done is set
    task automatic wait_done();
        logic [DATA_WIDTH-1:0] rd;
        logic                  err;
        int                    start_cycle;
        start_cycle = cycle_cnt;
        rd          = '0;
        while (!rd[0] && (cycle_cnt - start_cycle) < 2000) begin
            apb_xfer(1'b0, ADDR_STATUS, '0, rd, err);
        end
        if (!rd[0]) begin
            drv_errors = drv_errors + 1;
            $display("ERROR: done not seen within 2000 cycles");
        end
    endtask

    task automatic run_script();
        int                    fd;
        int                    n;
        string                 line;
        string                 op;
        logic [31:0]           a;
        logic [31:0]           d;
        logic [31:0]           x;
        logic [DATA_WIDTH-1:0] rd;
        logic                  err;
        fd = $fopen("tb/matmul_input.txt", "r");
        if (fd == 0) begin
            drv_errors = drv_errors + 1;
            $display("ERROR: cannot open the stimulus file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%s %h %h %h", op, a, d, x);
            if (n < 1 || op == "#") begin
                continue;
            end
            case (op)
                "W": apb_xfer(1'b1, a[PADDR_WIDTH-1:0], d, rd, err);
                "F": begin
                    for (int w = 0; w < int'(x); w++) begin
                        apb_xfer(1'b1, PADDR_WIDTH'(a + w), d, rd, err);
                    end
                end
                "R": begin
                    exp_data = d;
                    exp_err  = x[0];
                    exp_en   = 1'b1;
                    apb_xfer(1'b0, a[PADDR_WIDTH-1:0], '0, rd, err);
                end
                "P": wait_done();
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        apb        = 1'b0;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        exp_en     = 1'b0;
        exp_data   = '0;
        exp_err    = 1'b0;
        drv_errors = 0;
        cycle_cnt  = 0;
        repeat (4) @(posedge apb);
        #1;
        arst_n = 1'b1;
        run_script();
        repeat (2) @(posedge apb);
        $display("Errors: %0d from monitor, %0d from driver", mon_errors, drv_errors);
        if (mon_errors + drv_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/mmu_pkg.sv
hw/mmu_ctrl_if.sv
hw/apb_csr_regs.sv
hw/mat_scratchpad.sv
hw/matmul_engine.sv
hw/matmul_status.sv
hw/matmul_top.sv
tb/matmul_chk.sv
tb/matmul_monitor.sv
tb/matmul_tb.sv
